//--- sim/soc_golden.txt
# Columns: op addr data, all fields hex, unused fields 0
# W write, R read and compare, B buttons, T wait cycles, X reset sequence
# Address 0BRR is bank B register RR, 1000 reads and clears the latched irq flags
# Register access
W 101 00000003
R 101 00000003
R 103 00000000
R 10F 4D4F4E45
R 10E 00000003
R 500 00000000
R 50F 00000000
B 5 0
T 8 0
R 100 00000005
# GPIO interrupt, enabled then masked
W 102 00000007
R 102 00000007
R 1000 00000000
B 4 0
T 8 0
R 1000 00000004
W 102 00000000
B 1 0
T 8 0
R 1000 00000000
# Timer 0 one-shot, compare 40
W 105 00000028
W 104 00000001
T 64 0
R 106 00000028
R 104 00000000
R 1000 00000008
# Timer 1 autorestart, compare 10
W 109 0000000A
W 108 00000003
T 20 0
R 1000 00000010
T 20 0
R 1000 00000010
R 108 00000003
# Reset by system id write
W 10F 00000000
X 0 0
R 101 00000000
R 108 00000000
# Reset by all three buttons
W 101 00000002
R 101 00000002
B 7 0
T 4 0
B 0 0
X 0 0
R 101 00000000

//--- filelist.f
logic/soc_pkg.sv
logic/soc_reset_gen.sv
logic/csr_bridge.sv
logic/sysctl_timer.sv
logic/sysctl.sv
logic/soc_top.sv
sim/tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_ctrl_core

sources:
  # RTL in compile order
  - files:
      - logic/soc_pkg.sv
      - logic/soc_reset_gen.sv
      - logic/csr_bridge.sv
      - logic/sysctl_timer.sv
      - logic/sysctl.sv
      - logic/soc_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_soc_top.sv

//--- sim/tb_soc_top.sv
module tb_soc_top
	import soc_pkg::*;
();

	localparam string       GOLDEN_FILE   = "sim/soc_golden.txt";
	// Two debounce ranges per reset sequence
	localparam int unsigned RESET_CYCLES  = 2 * (1 << 10);
	localparam logic [31:0] FLAG_BASE     = 32'h1000;
	// Bank 1, register 1
	localparam logic [31:0] GPIO_OUT_CODE = 32'h101;

	logic        sys_clk;
	logic        trigger_reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [2:0]  btn;
	logic [1:0]  led;
	logic [31:0] irq;
	logic        flash_rst_n;
	logic        periph_rst_n;

	logic [31:0] irq_seen;
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 0;
	int unsigned errors = 0;
	int unsigned checks = 0;
	int          fd;

	soc_top UUT (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_req_i       (wb_req),
		.wb_rsp_o       (wb_rsp),
		.btn_i          (btn),
		.led_o          (led),
		.irq_o          (irq),
		.flash_rst_n_o  (flash_rst_n),
		.periph_rst_n_o (periph_rst_n)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Latch irq bits on the falling edge, away from the drive points
	always @(negedge sys_clk) begin
		for (int i = 0; i < 32; i++) begin
			if (irq[i] === 1'b1) begin
				irq_seen[i] = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic end_run(input logic aborted);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (!aborted && errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	// Golden code 0BRR is bank B, register RR, as a Wishbone byte address
	function automatic logic [31:0] csr_byte_addr(input logic [31:0] code);
		logic [13:0] word;
		word = {code[11:8], 2'b00, code[7:0]};
		return {16'h0, word, 2'b00};
	endfunction

	task automatic wb_access(input logic we, input logic [31:0] code,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge sys_clk);
		#1;
		wb_req.adr = csr_byte_addr(code);
		wb_req.dat = wdata;
		wb_req.sel = 4'hf;
		wb_req.we  = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		@(posedge sys_clk);
		#1;
		while (wb_rsp.ack !== 1'b1) begin
			@(posedge sys_clk);
			#1;
		end
		rdata      = wb_rsp.dat;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic read_and_check(input logic [31:0] code, input logic [31:0] expected);
		logic [31:0] rdata;
		if (code >= FLAG_BASE) begin
			check_value(irq_seen, expected, "latched irq flags");
			irq_seen = '0;
		end else begin
			wb_access(1'b0, code, 32'h0, rdata);
			check_value(rdata, expected, $sformatf("read of register %h", code));
			if (code == GPIO_OUT_CODE) begin
				check_value({30'b0, led}, expected, "led output");
			end
		end
	endtask

	task automatic drive_buttons(input logic [2:0] value);
		@(posedge sys_clk);
		#1;
		btn = value;
	endtask

	task automatic wait_reset_start();
		int unsigned n;
		n = 0;
		while (periph_rst_n !== 1'b0 && n < 16) begin
			@(posedge sys_clk);
			#1;
			n++;
		end
		if (periph_rst_n !== 1'b0) begin
			errors++;
			$display("The reset sequence did not start within 16 cycles");
		end else begin
			check_value({31'b0, flash_rst_n}, 32'd0, "flash reset at start of reset");
		end
	endtask

	// Flash must be seen released in an earlier cycle than the peripherals
	task automatic wait_reset_release();
		logic flash_up;
		flash_up = 1'b0;
		while (periph_rst_n !== 1'b1) begin
			if (flash_rst_n === 1'b1) begin
				flash_up = 1'b1;
			end
			@(posedge sys_clk);
			#1;
		end
		check_value({31'b0, flash_up}, 32'd1, "flash released before peripherals");
		irq_seen = '0;
	endtask

	// ----------------------------------------
	// Golden file
	// ----------------------------------------
	task automatic scan_golden(input int f, output int unsigned limit);
		logic [7:0]       op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [8*128-1:0] line;
		int               n;
		int unsigned      total;
		total = RESET_CYCLES;
		while ($fscanf(f, " %c", op) == 1) begin
			if (op == "#") begin
				n = $fgets(line, f);
			end else begin
				n = $fscanf(f, " %h %h", a, b);
				case (op)
					"W", "R": total += 8;
					"T":      total += a;
					"X":      total += RESET_CYCLES;
					default:  total += 1;
				endcase
			end
		end
		limit = 2 * total;
	endtask

	task automatic run_golden(input int f);
		logic [7:0]       op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      rdata;
		logic [8*128-1:0] line;
		int               n;
		while ($fscanf(f, " %c", op) == 1) begin
			if (op == "#") begin
				n = $fgets(line, f);
			end else begin
				n = $fscanf(f, " %h %h", a, b);
				if (n != 2) begin
					errors++;
					$display("A golden line with opcode %c has missing fields", op);
				end
				case (op)
					"W": wb_access(1'b1, a, b, rdata);
					"R": read_and_check(a, b);
					"B": drive_buttons(a[2:0]);
					"T": repeat (a) @(posedge sys_clk);
					"X": begin
						wait_reset_start();
						wait_reset_release();
					end
					default: begin
						errors++;
						$display("Unknown opcode %c in the golden file", op);
					end
				endcase
			end
		end
	endtask

	// Watchdog
	initial begin
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		end_run(1'b1);
	end

	initial begin
		int unsigned limit;
		trigger_reset = 1'b1;
		btn           = 3'b000;
		wb_req        = '0;
		irq_seen      = '0;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the golden file %s", GOLDEN_FILE);
			end_run(1'b1);
		end else begin
			scan_golden(fd, limit);
			$fclose(fd);
			fd = $fopen(GOLDEN_FILE, "r");
			cycle_limit = limit;
			repeat (2) @(posedge sys_clk);
			#1;
			check_value({30'b0, flash_rst_n, periph_rst_n}, 32'd0,
				"resets held while trigger is high");
			trigger_reset = 1'b0;
			wait_reset_release();
			run_golden(fd);
			$fclose(fd);
			end_run(1'b0);
		end
	end

endmodule

//--- logic/soc_top.sv
module soc_top
	import soc_pkg::*;
#(
	parameter int unsigned           RST_DEBOUNCE_W = 10,
	parameter int unsigned           FLASH_RST_W    = 8,
	parameter logic [CSR_DATA_W-1:0] SYSTEM_ID      = 32'h4D4F_4E45,
	parameter int unsigned           N_GPIO_IN      = 3,
	parameter int unsigned           N_GPIO_OUT     = 2
) (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,
	input  wb_req_t               wb_req_i,
	output wb_rsp_t               wb_rsp_o,
	input  logic [N_GPIO_IN-1:0]  btn_i,
	output logic [N_GPIO_OUT-1:0] led_o,
	output logic [IRQ_W-1:0]      irq_o,
	output logic                  flash_rst_n_o,
	output logic                  periph_rst_n_o
);

	logic                  sys_rst;
	logic                  hard_reset;
	csr_req_t              csr_req;
	logic [CSR_DATA_W-1:0] csr_rdata;
	logic [CSR_DATA_W-1:0] sysctl_rdata;
	logic                  gpio_irq;
	logic                  timer0_irq;
	logic                  timer1_irq;

	// ----------------------------------------
	// Reset chain
	// ----------------------------------------
	soc_reset_gen #(
		.RST_DEBOUNCE_W (RST_DEBOUNCE_W),
		.FLASH_RST_W    (FLASH_RST_W)
	) u_reset_gen (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.hard_reset_i   (hard_reset),
		.buttons_i      (btn_i[2:0]),
		.sys_rst_o      (sys_rst),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// Bank read data is the OR of all banks, only sysctl is left
	assign csr_rdata = sysctl_rdata;

	csr_bridge u_csr_bridge (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.csr_req_o   (csr_req),
		.csr_rdata_i (csr_rdata)
	);

	sysctl #(
		.SYSTEM_ID    (SYSTEM_ID),
		.N_GPIO_IN    (N_GPIO_IN),
		.N_GPIO_OUT   (N_GPIO_OUT)
	) u_sysctl (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_req_i    (csr_req),
		.csr_rdata_o  (sysctl_rdata),
		.gpio_in_i    (btn_i),
		.gpio_out_o   (led_o),
		.gpio_irq_o   (gpio_irq),
		.timer0_irq_o (timer0_irq),
		.timer1_irq_o (timer1_irq),
		.hard_reset_o (hard_reset)
	);

	// Interrupt vector, dropped sources stay zero
	always_comb begin
		irq_o             = '0;
		irq_o[IRQ_GPIO]   = gpio_irq;
		irq_o[IRQ_TIMER0] = timer0_irq;
		irq_o[IRQ_TIMER1] = timer1_irq;
	end

endmodule

//--- logic/sysctl.sv
module sysctl
	import soc_pkg::*;
#(
	parameter logic [CSR_DATA_W-1:0] SYSTEM_ID  = 32'h0,
	parameter int unsigned           N_GPIO_IN  = 3,
	parameter int unsigned           N_GPIO_OUT = 2
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  csr_req_t              csr_req_i,
	output logic [CSR_DATA_W-1:0] csr_rdata_o,
	input  logic [N_GPIO_IN-1:0]  gpio_in_i,
	output logic [N_GPIO_OUT-1:0] gpio_out_o,
	output logic                  gpio_irq_o,
	output logic                  timer0_irq_o,
	output logic                  timer1_irq_o,
	output logic                  hard_reset_o
);

	logic                  sel;
	logic                  wr;
	csr_reg_t              idx;
	logic [N_GPIO_IN-1:0]  gpio_meta_q;
	logic [N_GPIO_IN-1:0]  gpio_sync_q;
	logic [N_GPIO_IN-1:0]  gpio_prev_q;
	logic [N_GPIO_IN-1:0]  irqen_q;
	logic [N_GPIO_OUT-1:0] gpio_out_q;
	logic                  gpio_irq_q;
	logic                  hard_reset_q;
	logic [CSR_DATA_W-1:0] rdata_q;
	logic [1:0]            t0_ctrl;
	logic [1:0]            t1_ctrl;
	logic [CSR_DATA_W-1:0] t0_cmp;
	logic [CSR_DATA_W-1:0] t1_cmp;
	logic [CSR_DATA_W-1:0] t0_cnt;
	logic [CSR_DATA_W-1:0] t1_cnt;

	assign sel = (csr_req_i.addr.field.bank == SYSCTL_BANK);
	assign idx = csr_req_i.addr.field.idx;
	assign wr  = sel && csr_req_i.we;

	// ----------------------------------------
	// GPIO
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta_q <= gpio_in_i;
		gpio_sync_q <= gpio_meta_q;
		gpio_prev_q <= gpio_sync_q;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_q   <= '0;
			irqen_q      <= '0;
			gpio_irq_q   <= 1'b0;
			hard_reset_q <= 1'b0;
		end else begin
			// Any edge on an enabled input
			gpio_irq_q   <= |((gpio_sync_q ^ gpio_prev_q) & irqen_q);
			hard_reset_q <= wr && (idx == REG_SYSID);
			if (wr && (idx == REG_GPIO_OUT)) begin
				gpio_out_q <= csr_req_i.wdata[N_GPIO_OUT-1:0];
			end
			if (wr && (idx == REG_GPIO_IRQEN)) begin
				irqen_q <= csr_req_i.wdata[N_GPIO_IN-1:0];
			end
		end
	end

	// Timers
	sysctl_timer u_timer0 (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_i),
		.ctrl_we_i (wr && (idx == REG_T0_CTRL)),
		.cmp_we_i  (wr && (idx == REG_T0_CMP)),
		.cnt_we_i  (wr && (idx == REG_T0_CNT)),
		.wdata_i   (csr_req_i.wdata),
		.ctrl_o    (t0_ctrl),
		.cmp_o     (t0_cmp),
		.cnt_o     (t0_cnt),
		.irq_o     (timer0_irq_o)
	);

	sysctl_timer u_timer1 (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst_i),
		.ctrl_we_i (wr && (idx == REG_T1_CTRL)),
		.cmp_we_i  (wr && (idx == REG_T1_CMP)),
		.cnt_we_i  (wr && (idx == REG_T1_CNT)),
		.wdata_i   (csr_req_i.wdata),
		.ctrl_o    (t1_ctrl),
		.cmp_o     (t1_cmp),
		.cnt_o     (t1_cnt),
		.irq_o     (timer1_irq_o)
	);

	// ----------------------------------------
	// Read mux, zero when another bank is addressed
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i || !sel) begin
			rdata_q <= '0;
		end else begin
			case (idx)
				REG_GPIO_IN:    rdata_q <= CSR_DATA_W'(gpio_sync_q);
				REG_GPIO_OUT:   rdata_q <= CSR_DATA_W'(gpio_out_q);
				REG_GPIO_IRQEN: rdata_q <= CSR_DATA_W'(irqen_q);
				REG_T0_CTRL:    rdata_q <= CSR_DATA_W'(t0_ctrl);
				REG_T0_CMP:     rdata_q <= t0_cmp;
				REG_T0_CNT:     rdata_q <= t0_cnt;
				REG_T1_CTRL:    rdata_q <= CSR_DATA_W'(t1_ctrl);
				REG_T1_CMP:     rdata_q <= t1_cmp;
				REG_T1_CNT:     rdata_q <= t1_cnt;
				REG_CAPS:       rdata_q <= SOC_CAPABILITIES;
				REG_SYSID:      rdata_q <= SYSTEM_ID;
				default:        rdata_q <= '0;
			endcase
		end
	end

	assign csr_rdata_o  = rdata_q;
	assign gpio_out_o   = gpio_out_q;
	assign gpio_irq_o   = gpio_irq_q;
	assign hard_reset_o = hard_reset_q;

endmodule

//--- logic/sysctl_timer.sv
module sysctl_timer
	import soc_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  logic                  ctrl_we_i,
	input  logic                  cmp_we_i,
	input  logic                  cnt_we_i,
	input  logic [CSR_DATA_W-1:0] wdata_i,
	output logic [1:0]            ctrl_o,
	output logic [CSR_DATA_W-1:0] cmp_o,
	output logic [CSR_DATA_W-1:0] cnt_o,
	output logic                  irq_o
);

	logic [1:0]            ctrl_q;
	logic [CSR_DATA_W-1:0] cmp_q;
	logic [CSR_DATA_W-1:0] cnt_q;
	logic                  irq_q;
	logic                  enabled;
	logic                  autorestart;
	logic                  hit;

	assign enabled     = ctrl_q[TCTRL_EN_BIT];
	assign autorestart = ctrl_q[TCTRL_AR_BIT];
	assign hit         = enabled && (cnt_q == cmp_q);

	// ----------------------------------------
	// Control and interrupt
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ctrl_q <= '0;
			irq_q  <= 1'b0;
		end else begin
			irq_q <= hit;
			if (ctrl_we_i) begin
				ctrl_q <= wdata_i[1:0];
			end else if (hit && !autorestart) begin
				// One-shot, stop and keep the count at compare
				ctrl_q[TCTRL_EN_BIT] <= 1'b0;
			end
		end
	end

	// Counter and compare value
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			cmp_q <= '0;
			cnt_q <= '0;
		end else begin
			if (cmp_we_i) begin
				cmp_q <= wdata_i;
			end
			if (cnt_we_i) begin
				cnt_q <= wdata_i;
			end else if (hit) begin
				if (autorestart) begin
					cnt_q <= '0;
				end
			end else if (enabled) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign ctrl_o = ctrl_q;
	assign cmp_o  = cmp_q;
	assign cnt_o  = cnt_q;
	assign irq_o  = irq_q;

endmodule

//--- logic/csr_bridge.sv
module csr_bridge
	import soc_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,
	input  wb_req_t               wb_req_i,
	output wb_rsp_t               wb_rsp_o,
	output csr_req_t              csr_req_o,
	input  logic [CSR_DATA_W-1:0] csr_rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_ACK
	} state_t;

	state_t                state_q;
	logic                  ack_q;
	logic                  we_q;
	logic [CSR_ADDR_W-1:0] addr_q;
	logic [CSR_DATA_W-1:0] wdata_q;
	logic [CSR_DATA_W-1:0] rdata_q;
	logic                  start;

	// No new cycle while ack is still out, the master drops stb one cycle later
	assign start = (state_q == ST_IDLE) && wb_req_i.cyc && wb_req_i.stb && !ack_q;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
			ack_q   <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			we_q  <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (start) begin
						we_q    <= wb_req_i.we;
						state_q <= ST_READ;
					end
				end
				ST_READ: state_q <= ST_ACK;
				ST_ACK: begin
					ack_q   <= 1'b1;
					state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Word address and write data, held until the next cycle
	always_ff @(posedge sys_clk) begin
		if (start) begin
			addr_q  <= wb_req_i.adr[CSR_ADDR_W+1:2];
			wdata_q <= wb_req_i.dat;
		end
		// Bank data is registered, valid here for the held address
		if (state_q == ST_ACK) begin
			rdata_q <= csr_rdata_i;
		end
	end

	assign csr_req_o.addr.flat = addr_q;
	assign csr_req_o.we        = we_q;
	assign csr_req_o.wdata     = wdata_q;

	assign wb_rsp_o.dat = rdata_q;
	assign wb_rsp_o.ack = ack_q;

endmodule

//--- logic/soc_reset_gen.sv
module soc_reset_gen #(
	parameter int unsigned RST_DEBOUNCE_W = 10,
	parameter int unsigned FLASH_RST_W    = 8
) (
	input  logic       sys_clk,
	input  logic       trigger_reset,
	input  logic       hard_reset_i,
	input  logic [2:0] buttons_i,
	output logic       sys_rst_o,
	output logic       flash_rst_n_o,
	output logic       periph_rst_n_o
);

	logic                      trigger_q;
	logic [RST_DEBOUNCE_W-1:0] debounce_q;
	logic [FLASH_RST_W-1:0]    flash_cnt_q;
	logic                      sys_rst_q;

	// External reset, software request or all three buttons held
	always_ff @(posedge sys_clk) begin
		trigger_q <= trigger_reset | hard_reset_i | (&buttons_i);
	end

	// ----------------------------------------
	// Debounce counter for the system reset
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_q) begin
			debounce_q <= '1;
		end else if (debounce_q != '0) begin
			debounce_q <= debounce_q - 1'b1;
		end
		sys_rst_q <= trigger_q | (debounce_q != '0);
	end

	// Flash leaves reset early, the top bit sets after half the range
	always_ff @(posedge sys_clk) begin
		if (trigger_q) begin
			flash_cnt_q <= '0;
		end else if (!flash_cnt_q[FLASH_RST_W-1]) begin
			flash_cnt_q <= flash_cnt_q + 1'b1;
		end
	end

	assign sys_rst_o      = sys_rst_q;
	assign periph_rst_n_o = ~sys_rst_q;
	assign flash_rst_n_o  = flash_cnt_q[FLASH_RST_W-1];

endmodule

//--- logic/soc_pkg.sv
package soc_pkg;

	// ----------------------------------------
	// CSR bus geometry
	// ----------------------------------------
	localparam int unsigned CSR_ADDR_W = 14;
	localparam int unsigned CSR_BANK_W = 4;
	localparam int unsigned CSR_REG_W  = CSR_ADDR_W - CSR_BANK_W;
	localparam int unsigned CSR_DATA_W = 32;

	// Wishbone side of the bridge
	localparam int unsigned WB_ADDR_W = 32;
	localparam int unsigned WB_SEL_W  = CSR_DATA_W / 8;

	typedef logic [CSR_REG_W-1:0] csr_reg_t;

	typedef struct packed {
		logic [CSR_BANK_W-1:0] bank;
		csr_reg_t              idx;
	} csr_field_t;

	// Flat word address for the bridge, bank/register split for the banks
	typedef union packed {
		logic [CSR_ADDR_W-1:0] flat;
		csr_field_t            field;
	} csr_addr_u;

	typedef struct packed {
		csr_addr_u             addr;
		logic                  we;
		logic [CSR_DATA_W-1:0] wdata;
	} csr_req_t;

	typedef struct packed {
		logic [WB_ADDR_W-1:0]  adr;
		logic [CSR_DATA_W-1:0] dat;
		logic [WB_SEL_W-1:0]   sel;
		logic                  we;
		logic                  cyc;
		logic                  stb;
	} wb_req_t;

	typedef struct packed {
		logic [CSR_DATA_W-1:0] dat;
		logic                  ack;
	} wb_rsp_t;

	// ----------------------------------------
	// System controller register map
	// ----------------------------------------
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;

	localparam csr_reg_t REG_GPIO_IN    = 10'd0;
	localparam csr_reg_t REG_GPIO_OUT   = 10'd1;
	localparam csr_reg_t REG_GPIO_IRQEN = 10'd2;
	localparam csr_reg_t REG_T0_CTRL    = 10'd4;
	localparam csr_reg_t REG_T0_CMP     = 10'd5;
	localparam csr_reg_t REG_T0_CNT     = 10'd6;
	localparam csr_reg_t REG_T1_CTRL    = 10'd8;
	localparam csr_reg_t REG_T1_CMP     = 10'd9;
	localparam csr_reg_t REG_T1_CNT     = 10'd10;
	localparam csr_reg_t REG_CAPS       = 10'd14;
	localparam csr_reg_t REG_SYSID      = 10'd15;

	// Timer control word
	localparam int unsigned TCTRL_EN_BIT = 0;
	localparam int unsigned TCTRL_AR_BIT = 1;

	// Interrupt vector, positions as on the full SoC
	localparam int unsigned IRQ_W      = 32;
	localparam int unsigned IRQ_GPIO   = 2;
	localparam int unsigned IRQ_TIMER0 = 3;
	localparam int unsigned IRQ_TIMER1 = 4;

	// Bit 0 GPIO, bit 1 timers
	localparam logic [CSR_DATA_W-1:0] SOC_CAPABILITIES = 32'h0000_0003;

endpackage
